// ==== rtl/tsc_defines.svh ====
`ifndef TSC_DEFINES_SVH
`define TSC_DEFINES_SVH

// data and instruction width
`define TSC_WORD_SIZE 16

// architectural registers
`define TSC_NUM_REGS 4

// width of a register index
`define TSC_REG_BITS 2

`endif

// ==== rtl/tsc_pkg.sv ====
`include "tsc_defines.svh"

package tsc_pkg;

	typedef enum logic [3:0] {
		OP_ADI   = 4'd4,
		OP_ORI   = 4'd5,
		OP_LHI   = 4'd6,
		OP_RTYPE = 4'd15
	} opcode_e;

	typedef enum logic [5:0] {
		FN_ADD = 6'd0,
		FN_SUB = 6'd1,
		FN_AND = 6'd2,
		FN_ORR = 6'd3,
		FN_NOT = 6'd4,
		FN_TCP = 6'd5,
		FN_SHL = 6'd6,
		FN_SHR = 6'd7,
		FN_WWD = 6'd28
	} funct_e;

	typedef struct packed {
		opcode_e                  opcode;
		logic [`TSC_REG_BITS-1:0] rs;
		logic [`TSC_REG_BITS-1:0] rt;
		logic [`TSC_REG_BITS-1:0] rd;
		funct_e                   funct;
	} instr_r_s;

	typedef struct packed {
		opcode_e                  opcode;
		logic [`TSC_REG_BITS-1:0] rs;
		logic [`TSC_REG_BITS-1:0] rt;
		logic [7:0]               imm;
	} instr_i_s;

	// same 16-bit word, read as R-type or I-type by opcode
	typedef union packed {
		instr_r_s r;
		instr_i_s i;
	} instr_u;

	typedef enum logic [3:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_NOT,
		ALU_TCP,
		ALU_SHL,
		ALU_SHR,
		ALU_PASS_A,
		ALU_PASS_B
	} alu_op_e;

	typedef enum logic [1:0] {
		KIND_REG_WRITE = 2'd0,
		KIND_OUTPUT    = 2'd1,
		KIND_ILLEGAL   = 2'd2
	} result_kind_e;

	typedef struct packed {
		alu_op_e                   alu_op;
		logic [`TSC_WORD_SIZE-1:0] a;
		logic [`TSC_WORD_SIZE-1:0] b;
		logic [`TSC_REG_BITS-1:0]  dest;
		result_kind_e              kind;
	} exec_op_s;

	typedef struct packed {
		result_kind_e              kind;
		logic [`TSC_REG_BITS-1:0]  dest;
		logic [`TSC_WORD_SIZE-1:0] value;
	} result_s;

endpackage

// ==== rtl/tsc_regfile.sv ====
`timescale 1ns/1ps
`include "tsc_defines.svh"

module tsc_regfile (
	input  logic                      clk,
	input  logic                      rst_n,
	input  logic [`TSC_REG_BITS-1:0]  rd_idx_a,
	input  logic [`TSC_REG_BITS-1:0]  rd_idx_b,
	output logic [`TSC_WORD_SIZE-1:0] rd_data_a,
	output logic [`TSC_WORD_SIZE-1:0] rd_data_b,
	input  logic                      wr_en,
	input  logic [`TSC_REG_BITS-1:0]  wr_idx,
	input  logic [`TSC_WORD_SIZE-1:0] wr_data
);

	logic [`TSC_WORD_SIZE-1:0] regs [`TSC_NUM_REGS];

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < `TSC_NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_en) begin
			regs[wr_idx] <= wr_data;
		end
	end

	// reads are combinational, a same-cycle write is not bypassed
	assign rd_data_a = regs[rd_idx_a];
	assign rd_data_b = regs[rd_idx_b];

	a_wr_idx_range: assert property (
		@(posedge clk) disable iff (!rst_n)
		wr_en |-> (!$isunknown(wr_idx) && (wr_idx < `TSC_NUM_REGS))
	);

endmodule

// ==== rtl/tsc_decode.sv ====
`timescale 1ns/1ps
`include "tsc_defines.svh"

module tsc_decode (
	input  logic                      clk,
	input  logic                      rst_n,
	input  tsc_pkg::instr_u           instr,
	input  logic                      instr_valid,
	output logic                      instr_ready,
	output logic [`TSC_REG_BITS-1:0]  rf_rd_idx_a,
	output logic [`TSC_REG_BITS-1:0]  rf_rd_idx_b,
	input  logic [`TSC_WORD_SIZE-1:0] rf_rd_data_a,
	input  logic [`TSC_WORD_SIZE-1:0] rf_rd_data_b,
	input  logic [`TSC_REG_BITS-1:0]  pend_exe_dest,
	input  tsc_pkg::result_kind_e     pend_exe_kind,
	input  logic                      pend_exe_valid,
	input  logic [`TSC_REG_BITS-1:0]  pend_res_dest,
	input  tsc_pkg::result_kind_e     pend_res_kind,
	input  logic                      pend_res_valid,
	output tsc_pkg::exec_op_s         dec_op,
	output logic                      dec_valid,
	input  logic                      exe_ready
);

	import tsc_pkg::*;

	alu_op_e                   alu_op;
	result_kind_e              kind;
	logic [`TSC_REG_BITS-1:0]  dest;
	logic [`TSC_WORD_SIZE-1:0] imm_val;
	logic                      use_a;
	logic                      use_b;
	logic                      use_imm;
	logic                      dec_wr;
	logic                      exe_wr;
	logic                      res_wr;
	logic                      hazard;
	logic                      load;
	exec_op_s                  next_op;

	assign rf_rd_idx_a = instr.r.rs;
	assign rf_rd_idx_b = instr.r.rt;

	always_comb begin
		alu_op  = ALU_PASS_A;
		kind    = KIND_ILLEGAL;
		dest    = '0;
		imm_val = '0;
		use_a   = 1'b0;
		use_b   = 1'b0;
		use_imm = 1'b0;
		case (instr.r.opcode)
			OP_RTYPE: begin
				kind  = KIND_REG_WRITE;
				dest  = instr.r.rd;
				use_a = 1'b1;
				case (instr.r.funct)
					FN_ADD: begin
						alu_op = ALU_ADD;
						use_b  = 1'b1;
					end
					FN_SUB: begin
						alu_op = ALU_SUB;
						use_b  = 1'b1;
					end
					FN_AND: begin
						alu_op = ALU_AND;
						use_b  = 1'b1;
					end
					FN_ORR: begin
						alu_op = ALU_OR;
						use_b  = 1'b1;
					end
					FN_NOT: alu_op = ALU_NOT;
					FN_TCP: alu_op = ALU_TCP;
					FN_SHL: alu_op = ALU_SHL;
					FN_SHR: alu_op = ALU_SHR;
					FN_WWD: begin
						// rs goes out as the record value
						kind = KIND_OUTPUT;
						dest = '0;
					end
					default: begin
						kind  = KIND_ILLEGAL;
						dest  = '0;
						use_a = 1'b0;
					end
				endcase
			end
			OP_ADI: begin
				alu_op  = ALU_ADD;
				kind    = KIND_REG_WRITE;
				dest    = instr.i.rt;
				use_a   = 1'b1;
				use_imm = 1'b1;
				imm_val = {{(`TSC_WORD_SIZE-8){instr.i.imm[7]}}, instr.i.imm};
			end
			OP_ORI: begin
				alu_op  = ALU_OR;
				kind    = KIND_REG_WRITE;
				dest    = instr.i.rt;
				use_a   = 1'b1;
				use_imm = 1'b1;
				imm_val = {{(`TSC_WORD_SIZE-8){1'b0}}, instr.i.imm};
			end
			OP_LHI: begin
				alu_op  = ALU_PASS_B;
				kind    = KIND_REG_WRITE;
				dest    = instr.i.rt;
				use_imm = 1'b1;
				imm_val = {instr.i.imm, {(`TSC_WORD_SIZE-8){1'b0}}};
			end
			default: ;
		endcase
	end

	// unused operands are zeroed, so an illegal record carries value 0
	assign next_op.alu_op = alu_op;
	assign next_op.a      = use_a ? rf_rd_data_a : '0;
	assign next_op.b      = use_imm ? imm_val : (use_b ? rf_rd_data_b : '0);
	assign next_op.dest   = dest;
	assign next_op.kind   = kind;

	// any register write still held downstream blocks a matching source
	assign dec_wr = dec_valid && (dec_op.kind == KIND_REG_WRITE);
	assign exe_wr = pend_exe_valid && (pend_exe_kind == KIND_REG_WRITE);
	assign res_wr = pend_res_valid && (pend_res_kind == KIND_REG_WRITE);

	assign hazard =
		(use_a && ((dec_wr && dec_op.dest == instr.r.rs) ||
			(exe_wr && pend_exe_dest == instr.r.rs) ||
			(res_wr && pend_res_dest == instr.r.rs))) ||
		(use_b && ((dec_wr && dec_op.dest == instr.r.rt) ||
			(exe_wr && pend_exe_dest == instr.r.rt) ||
			(res_wr && pend_res_dest == instr.r.rt)));

	assign load        = !dec_valid || exe_ready;
	assign instr_ready = load && !hazard;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			dec_valid <= 1'b0;
		end else if (load) begin
			dec_valid <= instr_valid && !hazard;
		end
	end

	always_ff @(posedge clk) begin
		if (instr_valid && instr_ready) begin
			dec_op <= next_op;
		end
	end

	a_dec_op_hold: assert property (
		@(posedge clk) disable iff (!rst_n)
		(dec_valid && !exe_ready) |=> (dec_valid && $stable(dec_op))
	);

endmodule

// ==== rtl/tsc_execute.sv ====
`timescale 1ns/1ps
`include "tsc_defines.svh"

module tsc_execute (
	input  logic                     clk,
	input  logic                     rst_n,
	input  tsc_pkg::exec_op_s        dec_op,
	input  logic                     dec_valid,
	output logic                     exe_ready,
	output tsc_pkg::result_s         exe_res,
	output logic                     exe_valid,
	input  logic                     res_ready,
	output logic [`TSC_REG_BITS-1:0] pend_exe_dest,
	output tsc_pkg::result_kind_e    pend_exe_kind,
	output logic                     pend_exe_valid
);

	import tsc_pkg::*;

	logic [`TSC_WORD_SIZE-1:0] alu_value;
	result_s                   next_res;

	// all arithmetic wraps at word width
	always_comb begin
		case (dec_op.alu_op)
			ALU_ADD:    alu_value = dec_op.a + dec_op.b;
			ALU_SUB:    alu_value = dec_op.a - dec_op.b;
			ALU_AND:    alu_value = dec_op.a & dec_op.b;
			ALU_OR:     alu_value = dec_op.a | dec_op.b;
			ALU_NOT:    alu_value = ~dec_op.a;
			ALU_TCP:    alu_value = ~dec_op.a + 1'b1;
			ALU_SHL:    alu_value = {dec_op.a[`TSC_WORD_SIZE-2:0], 1'b0};
			// arithmetic shift keeps the sign bit
			ALU_SHR:    alu_value = {dec_op.a[`TSC_WORD_SIZE-1], dec_op.a[`TSC_WORD_SIZE-1:1]};
			ALU_PASS_A: alu_value = dec_op.a;
			ALU_PASS_B: alu_value = dec_op.b;
			default:    alu_value = '0;
		endcase
	end

	assign next_res.kind  = dec_op.kind;
	assign next_res.dest  = dec_op.dest;
	assign next_res.value = alu_value;

	assign exe_ready = !exe_valid || res_ready;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			exe_valid <= 1'b0;
		end else if (exe_ready) begin
			exe_valid <= dec_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (dec_valid && exe_ready) begin
			exe_res <= next_res;
		end
	end

	// held record seen by the decode hazard check
	assign pend_exe_dest  = exe_res.dest;
	assign pend_exe_kind  = exe_res.kind;
	assign pend_exe_valid = exe_valid;

endmodule

// ==== rtl/tsc_result.sv ====
`timescale 1ns/1ps
`include "tsc_defines.svh"

module tsc_result (
	input  logic                      clk,
	input  logic                      rst_n,
	input  tsc_pkg::result_s          exe_res,
	input  logic                      exe_valid,
	output logic                      res_ready,
	output tsc_pkg::result_s          result,
	output logic                      result_valid,
	input  logic                      result_ready,
	output logic [`TSC_REG_BITS-1:0]  pend_dest,
	output tsc_pkg::result_kind_e     pend_kind,
	output logic                      pend_valid,
	output logic                      rf_wr_en,
	output logic [`TSC_REG_BITS-1:0]  rf_wr_idx,
	output logic [`TSC_WORD_SIZE-1:0] rf_wr_data,
	output logic [`TSC_WORD_SIZE-1:0] retired_count
);

	import tsc_pkg::*;

	logic accept;

	assign res_ready = !result_valid || result_ready;
	assign accept    = result_valid && result_ready;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			result_valid <= 1'b0;
		end else if (res_ready) begin
			result_valid <= exe_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (exe_valid && res_ready) begin
			result <= exe_res;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			retired_count <= '0;
		end else if (accept) begin
			retired_count <= retired_count + 1'b1;
		end
	end

	// register write lands on the same edge the record leaves
	assign rf_wr_en   = accept && (result.kind == KIND_REG_WRITE);
	assign rf_wr_idx  = result.dest;
	assign rf_wr_data = result.value;

	assign pend_dest  = result.dest;
	assign pend_kind  = result.kind;
	assign pend_valid = result_valid;

	a_retired_monotonic: assert property (
		@(posedge clk) disable iff (!rst_n)
		(retired_count == $past(retired_count)) ||
		(retired_count == $past(retired_count) + 16'd1)
	);

endmodule

// ==== rtl/tsc_pipeline_top.sv ====
`timescale 1ns/1ps
`include "tsc_defines.svh"

module tsc_pipeline_top (
	input  logic                      clk,
	input  logic                      rst_n,
	input  tsc_pkg::instr_u           instr,
	input  logic                      instr_valid,
	output logic                      instr_ready,
	output tsc_pkg::result_s          result,
	output logic                      result_valid,
	input  logic                      result_ready,
	output logic [`TSC_WORD_SIZE-1:0] retired_count
);

	import tsc_pkg::*;

	exec_op_s                  dec_op;
	logic                      dec_valid;
	logic                      exe_ready;
	result_s                   exe_res;
	logic                      exe_valid;
	logic                      res_ready;
	logic [`TSC_REG_BITS-1:0]  pend_exe_dest;
	result_kind_e              pend_exe_kind;
	logic                      pend_exe_valid;
	logic [`TSC_REG_BITS-1:0]  pend_res_dest;
	result_kind_e              pend_res_kind;
	logic                      pend_res_valid;
	logic [`TSC_REG_BITS-1:0]  rf_rd_idx_a;
	logic [`TSC_REG_BITS-1:0]  rf_rd_idx_b;
	logic [`TSC_WORD_SIZE-1:0] rf_rd_data_a;
	logic [`TSC_WORD_SIZE-1:0] rf_rd_data_b;
	logic                      rf_wr_en;
	logic [`TSC_REG_BITS-1:0]  rf_wr_idx;
	logic [`TSC_WORD_SIZE-1:0] rf_wr_data;

	tsc_regfile tsc_regfile_i (
		.clk       (clk),
		.rst_n     (rst_n),
		.rd_idx_a  (rf_rd_idx_a),
		.rd_idx_b  (rf_rd_idx_b),
		.rd_data_a (rf_rd_data_a),
		.rd_data_b (rf_rd_data_b),
		.wr_en     (rf_wr_en),
		.wr_idx    (rf_wr_idx),
		.wr_data   (rf_wr_data)
	);

	tsc_decode tsc_decode_i (
		.clk            (clk),
		.rst_n          (rst_n),
		.instr          (instr),
		.instr_valid    (instr_valid),
		.instr_ready    (instr_ready),
		.rf_rd_idx_a    (rf_rd_idx_a),
		.rf_rd_idx_b    (rf_rd_idx_b),
		.rf_rd_data_a   (rf_rd_data_a),
		.rf_rd_data_b   (rf_rd_data_b),
		.pend_exe_dest  (pend_exe_dest),
		.pend_exe_kind  (pend_exe_kind),
		.pend_exe_valid (pend_exe_valid),
		.pend_res_dest  (pend_res_dest),
		.pend_res_kind  (pend_res_kind),
		.pend_res_valid (pend_res_valid),
		.dec_op         (dec_op),
		.dec_valid      (dec_valid),
		.exe_ready      (exe_ready)
	);

	tsc_execute tsc_execute_i (
		.clk            (clk),
		.rst_n          (rst_n),
		.dec_op         (dec_op),
		.dec_valid      (dec_valid),
		.exe_ready      (exe_ready),
		.exe_res        (exe_res),
		.exe_valid      (exe_valid),
		.res_ready      (res_ready),
		.pend_exe_dest  (pend_exe_dest),
		.pend_exe_kind  (pend_exe_kind),
		.pend_exe_valid (pend_exe_valid)
	);

	tsc_result tsc_result_i (
		.clk           (clk),
		.rst_n         (rst_n),
		.exe_res       (exe_res),
		.exe_valid     (exe_valid),
		.res_ready     (res_ready),
		.result        (result),
		.result_valid  (result_valid),
		.result_ready  (result_ready),
		.pend_dest     (pend_res_dest),
		.pend_kind     (pend_res_kind),
		.pend_valid    (pend_res_valid),
		.rf_wr_en      (rf_wr_en),
		.rf_wr_idx     (rf_wr_idx),
		.rf_wr_data    (rf_wr_data),
		.retired_count (retired_count)
	);

endmodule

// ==== verif/tsc_tb.sv ====
`timescale 1ns/1ps
`include "tsc_defines.svh"

module tsc_tb;

	import tsc_pkg::*;

	localparam int NUM_INSTR = 400;
	// twenty cycles per instruction plus margin for reset and drain
	localparam int TIMEOUT_CYCLES = NUM_INSTR * 20 + 200;

	logic                      clk;
	logic                      rst_n;
	instr_u                    instr;
	logic                      instr_valid;
	logic                      instr_ready;
	result_s                   result;
	logic                      result_valid;
	logic                      result_ready;
	logic [`TSC_WORD_SIZE-1:0] retired_count;

	logic [31:0]               lfsr = 32'hc59f_5d62;
	logic [`TSC_WORD_SIZE-1:0] model_regs [`TSC_NUM_REGS];
	result_s                   expect_q [$];
	result_s                   exp_rec;
	int                        sent = 0;
	int                        issued = 0;
	int                        received = 0;
	int                        cycles = 0;
	int                        value_errors = 0;
	int                        flow_errors = 0;

	funct_e legal_functs [9] = '{FN_ADD, FN_SUB, FN_AND, FN_ORR, FN_NOT,
		FN_TCP, FN_SHL, FN_SHR, FN_WWD};

	tsc_pipeline_top tsc_pipeline_top_i (
		.clk           (clk),
		.rst_n         (rst_n),
		.instr         (instr),
		.instr_valid   (instr_valid),
		.instr_ready   (instr_ready),
		.result        (result),
		.result_valid  (result_valid),
		.result_ready  (result_ready),
		.retired_count (retired_count)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// fibonacci lfsr with taps 32 22 2 1
	// stepped once for every bit returned
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		logic        fb;
		v = '0;
		for (int k = 0; k < n; k++) begin
			fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
			lfsr = {lfsr[30:0], fb};
			v    = {v[30:0], fb};
		end
		return v;
	endfunction

	// seven picks in eight land on r1 or r2 so chains form often
	function automatic logic [`TSC_REG_BITS-1:0] pick_reg();
		logic [31:0] r;
		if (rand_bits(2) != 32'd0) begin
			r = rand_bits(1);
			return r[0] ? 2'd2 : 2'd1;
		end
		r = rand_bits(2);
		return r[1:0];
	endfunction

	function automatic instr_u make_instr(input int idx);
		instr_u      w;
		logic [31:0] r;
		logic [3:0]  op;
		logic [5:0]  fn;
		w = '0;
		if (idx < `TSC_NUM_REGS) begin
			// opening WWDs read every register straight after reset
			w.r.opcode = OP_RTYPE;
			w.r.rs     = idx[1:0];
			w.r.funct  = FN_WWD;
			return w;
		end
		w.r.rs = pick_reg();
		w.r.rt = pick_reg();
		w.r.rd = pick_reg();
		r = rand_bits(4);
		if (r[3:0] == 4'd0) begin
			r = rand_bits(1);
			if (r[0]) begin
				do begin
					r  = rand_bits(4);
					op = r[3:0];
				end while (op == OP_ADI || op == OP_ORI || op == OP_LHI || op == OP_RTYPE);
				w.r.opcode = opcode_e'(op);
			end else begin
				do begin
					r  = rand_bits(6);
					fn = r[5:0];
				end while (fn <= FN_SHR || fn == FN_WWD);
				w.r.opcode = OP_RTYPE;
				w.r.funct  = funct_e'(fn);
			end
		end else if (r[3:0] < 4'd5) begin
			r = rand_bits(2);
			case (r[1:0])
				2'd0:    w.i.opcode = OP_ADI;
				2'd1:    w.i.opcode = OP_ORI;
				default: w.i.opcode = OP_LHI;
			endcase
			r = rand_bits(8);
			w.i.imm = r[7:0];
		end else begin
			r = rand_bits(4);
			w.r.opcode = OP_RTYPE;
			w.r.funct  = legal_functs[r % 9];
		end
		return w;
	endfunction

	// sequential ISA model updating model_regs in program order
	function automatic result_s model_execute(input instr_u w);
		result_s                   r;
		logic [`TSC_WORD_SIZE-1:0] a;
		logic [`TSC_WORD_SIZE-1:0] b;
		a       = model_regs[w.r.rs];
		b       = model_regs[w.r.rt];
		r.kind  = KIND_ILLEGAL;
		r.dest  = '0;
		r.value = '0;
		case (w.r.opcode)
			OP_ADI: begin
				r.kind  = KIND_REG_WRITE;
				r.dest  = w.i.rt;
				r.value = a + {{8{w.i.imm[7]}}, w.i.imm};
			end
			OP_ORI: begin
				r.kind  = KIND_REG_WRITE;
				r.dest  = w.i.rt;
				r.value = a | {8'h00, w.i.imm};
			end
			OP_LHI: begin
				r.kind  = KIND_REG_WRITE;
				r.dest  = w.i.rt;
				r.value = {w.i.imm, 8'h00};
			end
			OP_RTYPE: begin
				r.kind = KIND_REG_WRITE;
				r.dest = w.r.rd;
				case (w.r.funct)
					FN_ADD:  r.value = a + b;
					FN_SUB:  r.value = a - b;
					FN_AND:  r.value = a & b;
					FN_ORR:  r.value = a | b;
					FN_NOT:  r.value = ~a;
					FN_TCP:  r.value = -a;
					FN_SHL:  r.value = a << 1;
					FN_SHR:  r.value = $signed(a) >>> 1;
					FN_WWD: begin
						r.kind  = KIND_OUTPUT;
						r.value = a;
					end
					default: r.kind = KIND_ILLEGAL;
				endcase
			end
			default: ;
		endcase
		if (r.kind == KIND_REG_WRITE) begin
			model_regs[r.dest] = r.value;
		end
		return r;
	endfunction

	task automatic check_reg_write(input result_s got, input result_s exp);
		if (got.kind !== exp.kind || got.dest !== exp.dest || got.value !== exp.value) begin
			value_errors++;
			$display("Error at %0t: reg write got kind %0d r%0d=%h, expected kind %0d r%0d=%h",
				$time, got.kind, got.dest, got.value, exp.kind, exp.dest, exp.value);
		end
	endtask

	task automatic check_output(input result_s got, input result_s exp);
		if (got.kind !== exp.kind || got.value !== exp.value) begin
			value_errors++;
			$display("Error at %0t: output got kind %0d value %h, expected kind %0d value %h",
				$time, got.kind, got.value, exp.kind, exp.value);
		end
	endtask

	task automatic check_illegal(input result_s got, input result_s exp);
		if (got.kind !== exp.kind) begin
			value_errors++;
			$display("Error at %0t: illegal record came back as kind %0d", $time, got.kind);
		end
	endtask

	always @(posedge clk) begin
		if (rst_n && result_valid && result_ready) begin
			if (retired_count !== received[15:0]) begin
				value_errors++;
				$display("Error at %0t: retired_count %0d before record %0d",
					$time, retired_count, received);
			end
			if (expect_q.size() == 0) begin
				flow_errors++;
				$display("result record at %0t arrived with nothing expected", $time);
			end else begin
				exp_rec = expect_q.pop_front();
				case (exp_rec.kind)
					KIND_REG_WRITE: check_reg_write(result, exp_rec);
					KIND_OUTPUT:    check_output(result, exp_rec);
					default:        check_illegal(result, exp_rec);
				endcase
			end
			received++;
		end
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("timeout after %0d cycles with %0d of %0d records received",
				cycles, received, NUM_INSTR);
			$display("RESULT: FAIL");
			$finish;
		end
	end

	initial begin
		for (int k = 0; k < `TSC_NUM_REGS; k++) begin
			model_regs[k] = '0;
		end
		rst_n        <= 1'b0;
		instr        <= '0;
		instr_valid  <= 1'b0;
		result_ready <= 1'b0;
		repeat (2) @(posedge clk);
		rst_n <= 1'b1;
		@(posedge clk);
		if (result_valid !== 1'b0 || retired_count !== '0) begin
			value_errors++;
			$display("Error at %0t: after reset result_valid=%b retired_count=%0d",
				$time, result_valid, retired_count);
		end
		while (sent < NUM_INSTR) begin
			@(posedge clk);
			if (instr_valid && instr_ready) begin
				expect_q.push_back(model_execute(instr));
				sent++;
			end
			result_ready <= (rand_bits(2) != 32'd0);
			// a held instruction stays put until it is taken
			if (!instr_valid || instr_ready) begin
				if (issued < NUM_INSTR && rand_bits(2) != 32'd0) begin
					instr       <= make_instr(issued);
					instr_valid <= 1'b1;
					issued++;
				end else begin
					instr_valid <= 1'b0;
				end
			end
		end
		while (received < NUM_INSTR) begin
			@(posedge clk);
			result_ready <= (rand_bits(2) != 32'd0);
		end
		@(posedge clk);
		if (retired_count !== NUM_INSTR[15:0] || expect_q.size() != 0) begin
			flow_errors++;
			$display("retired_count is %0d with %0d expected records left over",
				retired_count, expect_q.size());
		end
		$display("checks done: %0d value errors, %0d flow errors, %0d records received",
			value_errors, flow_errors, received);
		if (value_errors == 0 && flow_errors == 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

endmodule

// ==== verilog.f ====
+incdir+rtl
rtl/tsc_pkg.sv
rtl/tsc_regfile.sv
rtl/tsc_decode.sv
rtl/tsc_execute.sv
rtl/tsc_result.sv
rtl/tsc_pipeline_top.sv
verif/tsc_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build the pipeline testbench with Verilator, run it and check the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal --top-module tsc_tb \
	-f verilog.f -o tsc_sim \
	&& ./obj_dir/tsc_sim > sim.log 2>&1 \
	|| echo "build or simulation ended with an error"

cat sim.log 2>/dev/null
grep -q "^RESULT: PASS$" sim.log 2>/dev/null \
	&& echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }
